//--- verilog/qdr_phy_defs.svh
// QDRII write PHY widths
`ifndef QDR_PHY_DEFS_SVH
`define QDR_PHY_DEFS_SVH

// memory side, one QDRII x18 write port
`define MEM_DQ_WIDTH 18
`define MEM_DM_WIDTH 2
`define MEM_WRITE_DQS_WIDTH 2

// half rate, so each AFI clock carries two full-rate cycles
`define AFI_RATE_MULT 2

// four DDR slots of DQ and byte-write select per AFI word
`define AFI_DATA_WIDTH 72
`define AFI_DM_WIDTH 8

// one write enable per group per full-rate cycle
`define AFI_WEN_WIDTH 4

// pipeline depth between AFI and the shifters, zero is legal
`define NUM_WRITE_PATH_FLOP_STAGES 2

// 0 to 3 force that shift on every group, 4 takes the calibrated shifts
`define NUM_WRITE_FR_CYCLE_SHIFTS 4

// group index on the calibration port is one bit wider than needed
// so that a bad index can reach the shift control and be dropped there
`define CAL_GROUP_IDX_WIDTH 2

`endif

//--- verilog/ddr_slot_pkg.sv
// DDR slot layout types
`default_nettype none

package ddr_slot_pkg;

	// delay applied to one write group, counted in full-rate cycles
	typedef enum logic [1:0]
	{
		shift_none     = 2'd0,
		shift_one_fr   = 2'd1,
		shift_two_fr   = 2'd2,
		shift_three_fr = 2'd3
	} fr_shift_e;

	// a group word holds four slots, the low two are the earlier
	// full-rate cycle and the high two the later one

endpackage

`default_nettype wire

//--- verilog/wr_cal_cmd_pkg.sv
// write calibration command types
`default_nettype none

package wr_cal_cmd_pkg;

	// command opcodes from the calibration master, one strobe per command
	typedef enum logic [1:0]
	{
		op_nop       = 2'd0,
		op_set_group = 2'd1,
		op_set_all   = 2'd2,
		op_clear_all = 2'd3
	} shift_op_e;

	// op_set_group uses the group index, op_set_all ignores it and
	// op_clear_all ignores both the index and the shift value

endpackage

`default_nettype wire

//--- verilog/fr_cycle_shifter.sv
// full-rate cycle shifter
`default_nettype none

module fr_cycle_shifter #(
	parameter int DATA_WIDTH = 2
)
(
	input wire pll_afi_clk,
	input wire arst_n,
	input wire ddr_slot_pkg::fr_shift_e shift_by,
	input wire [DATA_WIDTH-1:0] datain,
	output logic [DATA_WIDTH-1:0] dataout
);

	localparam int HALF_WIDTH = DATA_WIDTH / 2;

	// the low half of a word is the earlier full-rate cycle
	logic [DATA_WIDTH-1:0] word_d1;
	logic [HALF_WIDTH-1:0] hi_d2;

	// ******************************
	// history of the input stream
	// ******************************

	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			word_d1 <= '0;
			hi_d2 <= '0;
		end
		else
		begin
			word_d1 <= datain;
			hi_d2 <= word_d1[DATA_WIDTH-1:HALF_WIDTH];
		end
	end

	// ******************************
	// half-word selection
	// ******************************

	// an odd shift straddles two words, so the halves swap position
	always_comb
	begin
		case (shift_by)
			ddr_slot_pkg::shift_none:
				dataout = datain;
			ddr_slot_pkg::shift_one_fr:
				dataout = {datain[HALF_WIDTH-1:0], word_d1[DATA_WIDTH-1:HALF_WIDTH]};
			ddr_slot_pkg::shift_two_fr:
				dataout = word_d1;
			ddr_slot_pkg::shift_three_fr:
				dataout = {word_d1[HALF_WIDTH-1:0], hi_d2};
			default:
				dataout = datain;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/write_shift_ctrl.sv
// write shift control
`default_nettype none

`include "qdr_phy_defs.svh"

module write_shift_ctrl
(
	input wire pll_afi_clk,
	input wire arst_n,
	input wire cal_cmd_valid,
	input wire wr_cal_cmd_pkg::shift_op_e cal_cmd_op,
	input wire [`CAL_GROUP_IDX_WIDTH-1:0] cal_cmd_group,
	input wire ddr_slot_pkg::fr_shift_e cal_cmd_shift,
	output logic [`MEM_WRITE_DQS_WIDTH*2-1:0] wr_fr_shifts
);

	localparam int NUM_GROUPS = `MEM_WRITE_DQS_WIDTH;

	ddr_slot_pkg::fr_shift_e shift_q [NUM_GROUPS];

	// ******************************
	// shift register bank
	// ******************************

	// each accepted strobe takes effect on the next edge
	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int g = 0; g < NUM_GROUPS; g++)
				shift_q[g] <= ddr_slot_pkg::shift_none;
		end
		else if (cal_cmd_valid)
		begin
			case (cal_cmd_op)
				wr_cal_cmd_pkg::op_set_group:
				begin
					// an index past the last group matches nothing
					for (int g = 0; g < NUM_GROUPS; g++)
					begin
						if (int'(cal_cmd_group) == g)
							shift_q[g] <= cal_cmd_shift;
					end
				end
				wr_cal_cmd_pkg::op_set_all:
				begin
					for (int g = 0; g < NUM_GROUPS; g++)
						shift_q[g] <= cal_cmd_shift;
				end
				wr_cal_cmd_pkg::op_clear_all:
				begin
					for (int g = 0; g < NUM_GROUPS; g++)
						shift_q[g] <= ddr_slot_pkg::shift_none;
				end
				default:
				begin
					// op_nop leaves every group alone
				end
			endcase
		end
	end

	// two bits per group, group 0 lowest
	for (genvar g = 0; g < NUM_GROUPS; g++)
	begin : pack_gen
		assign wr_fr_shifts[2*g +: 2] = shift_q[g];
	end

endmodule

`default_nettype wire

//--- verilog/write_datapath.sv
// QDRII write datapath
`default_nettype none

`include "qdr_phy_defs.svh"

module write_datapath
(
	input wire pll_afi_clk,
	input wire arst_n,
	input wire [`AFI_DATA_WIDTH-1:0] afi_wdata,
	input wire [`AFI_WEN_WIDTH-1:0] afi_wdata_valid,
	input wire [`AFI_DM_WIDTH-1:0] afi_dm,
	input wire [`MEM_WRITE_DQS_WIDTH*2-1:0] wr_fr_shifts,
	output logic [`AFI_DATA_WIDTH-1:0] phy_ddio_dq,
	output logic [`AFI_WEN_WIDTH-1:0] phy_ddio_wrdata_en,
	output logic [`AFI_DM_WIDTH-1:0] phy_ddio_wrdata_mask
);

	localparam int NUM_STAGES = `NUM_WRITE_PATH_FLOP_STAGES;
	localparam int NUM_SLOTS = `AFI_RATE_MULT * 2;
	localparam int DQ_GROUP_WIDTH = `MEM_DQ_WIDTH / `MEM_WRITE_DQS_WIDTH;
	localparam int DM_GROUP_WIDTH = `MEM_DM_WIDTH / `MEM_WRITE_DQS_WIDTH;

	logic [`AFI_DATA_WIDTH-1:0] dq_pre_shift;
	logic [`AFI_WEN_WIDTH-1:0] wen_pre_shift;
	logic [`AFI_DM_WIDTH-1:0] dm_pre_shift;

	// ******************************
	// flop stages
	// ******************************

	if (NUM_STAGES == 0)
	begin : no_stage_gen
		assign dq_pre_shift = afi_wdata;
		assign wen_pre_shift = afi_wdata_valid;
		assign dm_pre_shift = afi_dm;
	end
	else
	begin : stage_gen
		logic [`AFI_DATA_WIDTH-1:0] wdata_r [NUM_STAGES];
		logic [`AFI_WEN_WIDTH-1:0] wen_r [NUM_STAGES];
		logic [`AFI_DM_WIDTH-1:0] dm_r [NUM_STAGES];

		always_ff @(posedge pll_afi_clk)
		begin
			wdata_r[0] <= afi_wdata;
			dm_r[0] <= afi_dm;
			for (int s = 1; s < NUM_STAGES; s++)
			begin
				wdata_r[s] <= wdata_r[s-1];
				dm_r[s] <= dm_r[s-1];
			end
		end

		// the enable stages clear on reset
		always_ff @(posedge pll_afi_clk or negedge arst_n)
		begin
			if (!arst_n)
			begin
				for (int s = 0; s < NUM_STAGES; s++)
					wen_r[s] <= '0;
			end
			else
			begin
				wen_r[0] <= afi_wdata_valid;
				for (int s = 1; s < NUM_STAGES; s++)
					wen_r[s] <= wen_r[s-1];
			end
		end

		assign dq_pre_shift = wdata_r[NUM_STAGES-1];
		assign wen_pre_shift = wen_r[NUM_STAGES-1];
		assign dm_pre_shift = dm_r[NUM_STAGES-1];
	end

	// ******************************
	// per-group shift
	// ******************************

	for (genvar i = 0; i < `MEM_WRITE_DQS_WIDTH; i++)
	begin : grp_gen
		ddr_slot_pkg::fr_shift_e grp_shift;
		logic [DQ_GROUP_WIDTH*NUM_SLOTS-1:0] grp_dq_pre, grp_dq;
		logic [DM_GROUP_WIDTH*NUM_SLOTS-1:0] grp_dm_pre, grp_dm;
		logic [`AFI_RATE_MULT-1:0] grp_wen_pre, grp_wen;

		if (`NUM_WRITE_FR_CYCLE_SHIFTS < 4)
		begin : forced_shift_gen
			assign grp_shift = ddr_slot_pkg::fr_shift_e'(2'(`NUM_WRITE_FR_CYCLE_SHIFTS));
		end
		else
		begin : cal_shift_gen
			assign grp_shift = ddr_slot_pkg::fr_shift_e'(wr_fr_shifts[2*i +: 2]);
		end

		// gather this group's bits from every DDR slot and scatter them back
		for (genvar t = 0; t < NUM_SLOTS; t++)
		begin : slot_gen
			assign grp_dq_pre[t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				dq_pre_shift[t*`MEM_DQ_WIDTH + i*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
			assign phy_ddio_dq[t*`MEM_DQ_WIDTH + i*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				grp_dq[t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
			assign grp_dm_pre[t*DM_GROUP_WIDTH +: DM_GROUP_WIDTH] =
				dm_pre_shift[t*`MEM_DM_WIDTH + i*DM_GROUP_WIDTH +: DM_GROUP_WIDTH];
			assign phy_ddio_wrdata_mask[t*`MEM_DM_WIDTH + i*DM_GROUP_WIDTH +: DM_GROUP_WIDTH] =
				grp_dm[t*DM_GROUP_WIDTH +: DM_GROUP_WIDTH];
		end

		// enables are per full-rate cycle, not per slot
		for (genvar t = 0; t < `AFI_RATE_MULT; t++)
		begin : cycle_gen
			assign grp_wen_pre[t] = wen_pre_shift[i + t*`MEM_WRITE_DQS_WIDTH];
			assign phy_ddio_wrdata_en[i + t*`MEM_WRITE_DQS_WIDTH] = grp_wen[t];
		end

		fr_cycle_shifter #(.DATA_WIDTH(DQ_GROUP_WIDTH*NUM_SLOTS)) dq_shifter_inst
		(
			.pll_afi_clk(pll_afi_clk),
			.arst_n(arst_n),
			.shift_by(grp_shift),
			.datain(grp_dq_pre),
			.dataout(grp_dq)
		);

		fr_cycle_shifter #(.DATA_WIDTH(DM_GROUP_WIDTH*NUM_SLOTS)) dm_shifter_inst
		(
			.pll_afi_clk(pll_afi_clk),
			.arst_n(arst_n),
			.shift_by(grp_shift),
			.datain(grp_dm_pre),
			.dataout(grp_dm)
		);

		fr_cycle_shifter #(.DATA_WIDTH(`AFI_RATE_MULT)) wen_shifter_inst
		(
			.pll_afi_clk(pll_afi_clk),
			.arst_n(arst_n),
			.shift_by(grp_shift),
			.datain(grp_wen_pre),
			.dataout(grp_wen)
		);
	end

endmodule

`default_nettype wire

//--- verilog/qdr_write_phy.sv
// QDRII write PHY top
`default_nettype none

`include "qdr_phy_defs.svh"

module qdr_write_phy
(
	input wire pll_afi_clk,
	input wire arst_n,
	input wire cal_cmd_valid,
	input wire wr_cal_cmd_pkg::shift_op_e cal_cmd_op,
	input wire [`CAL_GROUP_IDX_WIDTH-1:0] cal_cmd_group,
	input wire ddr_slot_pkg::fr_shift_e cal_cmd_shift,
	input wire [`AFI_DATA_WIDTH-1:0] afi_wdata,
	input wire [`AFI_WEN_WIDTH-1:0] afi_wdata_valid,
	input wire [`AFI_DM_WIDTH-1:0] afi_dm,
	output logic [`AFI_DATA_WIDTH-1:0] phy_ddio_dq,
	output logic [`AFI_WEN_WIDTH-1:0] phy_ddio_wrdata_en,
	output logic [`AFI_DM_WIDTH-1:0] phy_ddio_wrdata_mask
);

	// calibrated per-group shifts, two bits per group
	logic [`MEM_WRITE_DQS_WIDTH*2-1:0] wr_fr_shifts;

	write_shift_ctrl write_shift_ctrl_inst
	(
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.cal_cmd_valid(cal_cmd_valid),
		.cal_cmd_op(cal_cmd_op),
		.cal_cmd_group(cal_cmd_group),
		.cal_cmd_shift(cal_cmd_shift),
		.wr_fr_shifts(wr_fr_shifts)
	);

	write_datapath write_datapath_inst
	(
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.afi_wdata(afi_wdata),
		.afi_wdata_valid(afi_wdata_valid),
		.afi_dm(afi_dm),
		.wr_fr_shifts(wr_fr_shifts),
		.phy_ddio_dq(phy_ddio_dq),
		.phy_ddio_wrdata_en(phy_ddio_wrdata_en),
		.phy_ddio_wrdata_mask(phy_ddio_wrdata_mask)
	);

endmodule

`default_nettype wire

//--- sim/tb_qdr_write_phy.sv
// QDRII write PHY testbench
`default_nettype none

`include "qdr_phy_defs.svh"

module tb_qdr_write_phy;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int GROUPS = `MEM_WRITE_DQS_WIDTH;
	localparam int DQ_GRP = `MEM_DQ_WIDTH / `MEM_WRITE_DQS_WIDTH;
	localparam int DM_GRP = `MEM_DM_WIDTH / `MEM_WRITE_DQS_WIDTH;
	localparam int ITEM_W = 2*DQ_GRP + 2*DM_GRP + 1;
	localparam int HIST_DEPTH = 32;
	// at the deepest shift the last word of a phase leaves the output five edges later
	localparam int TAIL_CHECKS = 5 * GROUPS * 2;

	// one group's share of a full-rate cycle: enable, two mask slots, two DQ slots
	typedef logic [ITEM_W-1:0] fr_item_t;

	logic pll_afi_clk;
	logic arst_n;
	logic cal_cmd_valid;
	wr_cal_cmd_pkg::shift_op_e cal_cmd_op;
	logic [`CAL_GROUP_IDX_WIDTH-1:0] cal_cmd_group;
	ddr_slot_pkg::fr_shift_e cal_cmd_shift;
	logic [`AFI_DATA_WIDTH-1:0] afi_wdata;
	logic [`AFI_WEN_WIDTH-1:0] afi_wdata_valid;
	logic [`AFI_DM_WIDTH-1:0] afi_dm;
	logic [`AFI_DATA_WIDTH-1:0] phy_ddio_dq;
	logic [`AFI_WEN_WIDTH-1:0] phy_ddio_wrdata_en;
	logic [`AFI_DM_WIDTH-1:0] phy_ddio_wrdata_mask;

	fr_item_t fr_hist [GROUPS][$];
	ddr_slot_pkg::fr_shift_e model_shift [GROUPS];
	int error_count = 0;
	int check_count = 0;
	int skip_cycles = 0;
	logic was_in_reset = 1'b1;
	logic timed_out = 1'b0;

	qdr_write_phy qdr_write_phy_inst
	(
		.pll_afi_clk(pll_afi_clk),
		.arst_n(arst_n),
		.cal_cmd_valid(cal_cmd_valid),
		.cal_cmd_op(cal_cmd_op),
		.cal_cmd_group(cal_cmd_group),
		.cal_cmd_shift(cal_cmd_shift),
		.afi_wdata(afi_wdata),
		.afi_wdata_valid(afi_wdata_valid),
		.afi_dm(afi_dm),
		.phy_ddio_dq(phy_ddio_dq),
		.phy_ddio_wrdata_en(phy_ddio_wrdata_en),
		.phy_ddio_wrdata_mask(phy_ddio_wrdata_mask)
	);

	always
	begin
		pll_afi_clk = 1'b0;
		#4;
		pll_afi_clk = 1'b1;
		#4;
	end

	// ******************************
	// reference model
	// ******************************

	// full-rate cycle h of a word covers slots 2h and 2h+1
	function automatic fr_item_t pack_fr(input logic [`AFI_DATA_WIDTH-1:0] dq,
		input logic [`AFI_DM_WIDTH-1:0] dm, input logic [`AFI_WEN_WIDTH-1:0] wen,
		input int g, input int h);
		fr_item_t item;
		int t;
		item = '0;
		for (int s = 0; s < 2; s++)
		begin
			t = 2*h + s;
			item[s*DQ_GRP +: DQ_GRP] = dq[t*`MEM_DQ_WIDTH + g*DQ_GRP +: DQ_GRP];
			item[2*DQ_GRP + s*DM_GRP +: DM_GRP] = dm[t*`MEM_DM_WIDTH + g*DM_GRP +: DM_GRP];
		end
		item[ITEM_W-1] = wen[g + h*GROUPS];
		return item;
	endfunction

	// the newest history entry is the later half of the word sampled this edge
	function automatic fr_item_t expected_fr(input int g, input int h);
		int k;
		int idx;
		k = (`NUM_WRITE_FR_CYCLE_SHIFTS < 4) ? `NUM_WRITE_FR_CYCLE_SHIFTS : int'(model_shift[g]);
		idx = fr_hist[g].size() - 2 + h - (`NUM_WRITE_PATH_FLOP_STAGES * 2 + k);
		if (idx < 0)
			return '0;
		return fr_hist[g][idx];
	endfunction

	// ******************************
	// compare process
	// ******************************

	always @(posedge pll_afi_clk)
	begin
		fr_item_t exp_item;
		fr_item_t got_item;
		int idx;
		// a word taken while the enable stages are held in reset carries no enable
		for (int g = 0; g < GROUPS; g++)
		begin
			for (int h = 0; h < 2; h++)
				fr_hist[g].push_back(pack_fr(afi_wdata, afi_dm,
					arst_n ? afi_wdata_valid : '0, g, h));
			while (fr_hist[g].size() > HIST_DEPTH)
				void'(fr_hist[g].pop_front());
		end
		if (!arst_n)
		begin
			for (int g = 0; g < GROUPS; g++)
				model_shift[g] = ddr_slot_pkg::shift_none;
			skip_cycles = 0;
			was_in_reset = 1'b1;
		end
		else
		begin
			if (was_in_reset)
			begin
				check_count++;
				assert (phy_ddio_wrdata_en == '0)
				else
				begin
					error_count++;
					$display("ERR %0t: wrdata_en is %b out of reset", $time, phy_ddio_wrdata_en);
				end
				was_in_reset = 1'b0;
			end
			if (skip_cycles > 0)
				skip_cycles--;
			else
			begin
				for (int g = 0; g < GROUPS; g++)
				begin
					for (int h = 0; h < 2; h++)
					begin
						exp_item = expected_fr(g, h);
						got_item = pack_fr(phy_ddio_dq, phy_ddio_wrdata_mask, phy_ddio_wrdata_en, g, h);
						check_count++;
						assert (got_item === exp_item)
						else
						begin
							error_count++;
							$display("ERR %0t: group %0d half %0d expected %h got %h",
								$time, g, h, exp_item, got_item);
						end
					end
				end
			end
			// the new shift is visible from the next edge on
			if (cal_cmd_valid)
			begin
				idx = int'(cal_cmd_group);
				case (cal_cmd_op)
					wr_cal_cmd_pkg::op_set_group:
						if (idx < GROUPS)
							model_shift[idx] = cal_cmd_shift;
					wr_cal_cmd_pkg::op_set_all:
						for (int g = 0; g < GROUPS; g++)
							model_shift[g] = cal_cmd_shift;
					wr_cal_cmd_pkg::op_clear_all:
						for (int g = 0; g < GROUPS; g++)
							model_shift[g] = ddr_slot_pkg::shift_none;
					default:
						idx = 0;
				endcase
				skip_cycles = 4;
			end
		end
	end

	// ******************************
	// stimulus
	// ******************************

	task automatic drive_word(input logic with_valid);
		logic [127:0] r;
		r = {$urandom(), $urandom(), $urandom(), $urandom()};
		@(posedge pll_afi_clk);
		afi_wdata <= r[`AFI_DATA_WIDTH-1:0];
		afi_dm <= r[`AFI_DATA_WIDTH +: `AFI_DM_WIDTH];
		afi_wdata_valid <= with_valid ? r[100 +: `AFI_WEN_WIDTH] : '0;
		cal_cmd_valid <= 1'b0;
	endtask

	task automatic run_traffic(input int cycles);
		repeat (cycles) drive_word(1'b1);
	endtask

	// valid stays low for two clocks on each side of the strobe
	task automatic send_cmd(input wr_cal_cmd_pkg::shift_op_e op,
		input logic [`CAL_GROUP_IDX_WIDTH-1:0] grp, input ddr_slot_pkg::fr_shift_e shift);
		repeat (2) drive_word(1'b0);
		@(posedge pll_afi_clk);
		cal_cmd_valid <= 1'b1;
		cal_cmd_op <= op;
		cal_cmd_group <= grp;
		cal_cmd_shift <= shift;
		repeat (2) drive_word(1'b0);
	endtask

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (arst_n !== 1'b1 && waited < 20)
		begin
			@(posedge pll_afi_clk);
			waited++;
		end
		if (arst_n !== 1'b1)
		begin
			timed_out = 1'b1;
			$display("timeout: reset was never released");
		end
	endtask

	// a phase ends once the compare process has covered the pipeline tail
	task automatic end_phase(input int n);
		int target;
		int waited;
		target = check_count + n;
		waited = 0;
		while (check_count < target && waited < n + 40)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		if (check_count < target)
		begin
			timed_out = 1'b1;
			$display("timeout: the compare process stopped checking the outputs");
		end
	endtask

	initial
	begin
		logic [31:0] r;
		void'($urandom(32'hce7b_b876));
		arst_n = 1'b0;
		cal_cmd_valid = 1'b0;
		cal_cmd_op = wr_cal_cmd_pkg::op_nop;
		cal_cmd_group = '0;
		cal_cmd_shift = ddr_slot_pkg::shift_none;
		afi_wdata = '0;
		// enables held high through reset must not show at the output
		afi_wdata_valid = '1;
		afi_dm = '0;
		repeat (10) @(posedge pll_afi_clk);
		arst_n <= 1'b1;
		wait_reset_release();
		if (!timed_out)
		begin
			run_traffic(20);
			end_phase(TAIL_CHECKS);
		end
		for (int s = 0; s < 4 && !timed_out; s++)
		begin
			send_cmd(wr_cal_cmd_pkg::op_set_all, 2'd0, ddr_slot_pkg::fr_shift_e'(2'(s)));
			run_traffic(16);
			end_phase(TAIL_CHECKS);
		end
		if (!timed_out)
		begin
			send_cmd(wr_cal_cmd_pkg::op_set_group, 2'd0, ddr_slot_pkg::shift_one_fr);
			send_cmd(wr_cal_cmd_pkg::op_set_group, 2'd1, ddr_slot_pkg::shift_three_fr);
			run_traffic(16);
			send_cmd(wr_cal_cmd_pkg::op_set_group, 2'd0, ddr_slot_pkg::shift_three_fr);
			send_cmd(wr_cal_cmd_pkg::op_set_group, 2'd1, ddr_slot_pkg::shift_two_fr);
			run_traffic(16);
			end_phase(TAIL_CHECKS);
		end
		if (!timed_out)
		begin
			send_cmd(wr_cal_cmd_pkg::op_clear_all, 2'd1, ddr_slot_pkg::shift_three_fr);
			run_traffic(12);
			send_cmd(wr_cal_cmd_pkg::op_set_all, 2'd0, ddr_slot_pkg::shift_two_fr);
			send_cmd(wr_cal_cmd_pkg::op_nop, 2'd0, ddr_slot_pkg::shift_three_fr);
			run_traffic(12);
			send_cmd(wr_cal_cmd_pkg::op_set_group, 2'd2, ddr_slot_pkg::shift_one_fr);
			send_cmd(wr_cal_cmd_pkg::op_set_group, 2'd3, ddr_slot_pkg::shift_three_fr);
			run_traffic(12);
			end_phase(TAIL_CHECKS);
		end
		for (int n = 0; n < 40 && !timed_out; n++)
		begin
			r = $urandom();
			send_cmd(wr_cal_cmd_pkg::shift_op_e'(r[1:0]), r[3:2], ddr_slot_pkg::fr_shift_e'(r[5:4]));
			run_traffic(5 + int'(r[11:8] % 4'd11));
		end
		if (!timed_out)
			end_phase(TAIL_CHECKS);
		$display("errors: %0d  checks: %0d", error_count, check_count);
		if (timed_out || error_count != 0 || check_count == 0)
			$display("RESULT: FAIL");
		else
			$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/ddr_slot_pkg.sv
verilog/wr_cal_cmd_pkg.sv
verilog/fr_cycle_shifter.sv
verilog/write_shift_ctrl.sv
verilog/write_datapath.sv
verilog/qdr_write_phy.sv
sim/tb_qdr_write_phy.sv

//--- Makefile
# Verilator build and run of the QDRII write PHY testbench

SIM = obj_dir/Vtb_qdr_write_phy
SOURCES = vlog.f verilog/qdr_phy_defs.svh $(wildcard verilog/*.sv) sim/tb_qdr_write_phy.sv

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

$(SIM): $(SOURCES)
	verilator --binary --assert --timing --timescale 1ns/1ps \
		--top-module tb_qdr_write_phy -f vlog.f

clean:
	rm -rf obj_dir sim.log
